/* common/rv_pkg.sv */
package rv_pkg;

    //////////////////////////////////////////////////
    // Word width
    //////////////////////////////////////////////////

    parameter int xlen = 32;

    // Field widths of the select and command codes.
    parameter int wb_sel_w  = 4;
    parameter int csr_cmd_w = 3;
    parameter int reg_addr_w = 5;

    //////////////////////////////////////////////////
    // Write-back select codes
    //////////////////////////////////////////////////

    // ALU result, also the fallback for unknown codes.
    parameter logic [wb_sel_w-1:0] wb_x     = 4'd0;
    // Loads, extended by width.
    parameter logic [wb_sel_w-1:0] wb_memb  = 4'd1;
    parameter logic [wb_sel_w-1:0] wb_membu = 4'd2;
    parameter logic [wb_sel_w-1:0] wb_memh  = 4'd3;
    parameter logic [wb_sel_w-1:0] wb_memhu = 4'd4;
    parameter logic [wb_sel_w-1:0] wb_memw  = 4'd5;
    // Return address for jal and jalr.
    parameter logic [wb_sel_w-1:0] wb_pc    = 4'd6;
    parameter logic [wb_sel_w-1:0] wb_csr   = 4'd7;

    //////////////////////////////////////////////////
    // CSR command codes
    //////////////////////////////////////////////////

    parameter logic [csr_cmd_w-1:0] csr_x     = 3'd0;
    parameter logic [csr_cmd_w-1:0] csr_w     = 3'd1;
    parameter logic [csr_cmd_w-1:0] csr_s     = 3'd2;
    parameter logic [csr_cmd_w-1:0] csr_c     = 3'd3;
    // The three codes below redirect to the trap vector.
    parameter logic [csr_cmd_w-1:0] csr_ecall = 3'd4;
    parameter logic [csr_cmd_w-1:0] csr_mret  = 3'd5;
    parameter logic [csr_cmd_w-1:0] csr_sret  = 3'd6;

    //////////////////////////////////////////////////
    // Register file write enable
    //////////////////////////////////////////////////

    parameter logic ren_s = 1'b1;

endpackage

/* writeback/next_pc_unit.sv */
`timescale 1ns/10ps

module next_pc_unit (
    input  logic [rv_pkg::xlen-1:0]      pc_plus4_i,
    input  logic                         br_flg_i,
    input  logic [rv_pkg::xlen-1:0]      br_target_i,
    input  logic                         jmp_flg_i,
    input  logic [rv_pkg::xlen-1:0]      alu_out_i,
    input  logic [rv_pkg::csr_cmd_w-1:0] csr_cmd_i,
    input  logic [rv_pkg::xlen-1:0]      trap_vector_i,
    output logic [rv_pkg::xlen-1:0]      next_pc_o,
    output logic                         branch_hazard_o
);

    logic is_trap;

    // Only ecall, mret and sret trap; csr_w, csr_s and csr_c do not.
    assign is_trap = (csr_cmd_i == rv_pkg::csr_ecall) ||
                     (csr_cmd_i == rv_pkg::csr_mret)  ||
                     (csr_cmd_i == rv_pkg::csr_sret);

    // Fixed priority: branch, jump, trap, sequential.
    always_comb begin
        if (br_flg_i) begin
            next_pc_o = br_target_i;
        end else if (jmp_flg_i) begin
            next_pc_o = alu_out_i;
        end else if (is_trap) begin
            next_pc_o = trap_vector_i;
        end else begin
            next_pc_o = pc_plus4_i;
        end
    end

    // Any redirect flushes the front end.
    assign branch_hazard_o = br_flg_i | jmp_flg_i | is_trap;

endmodule

/* writeback/writeback_stage.sv */
`timescale 1ns/10ps

module writeback_stage (
    input  logic [rv_pkg::xlen-1:0]      pc_i,
    input  logic [rv_pkg::wb_sel_w-1:0]  wb_sel_i,
    input  logic [rv_pkg::xlen-1:0]      csr_rdata_i,
    input  logic [rv_pkg::xlen-1:0]      mem_rdata_i,
    input  logic [rv_pkg::xlen-1:0]      alu_out_i,
    input  logic                         br_flg_i,
    input  logic [rv_pkg::xlen-1:0]      br_target_i,
    input  logic                         jmp_flg_i,
    input  logic [rv_pkg::csr_cmd_w-1:0] csr_cmd_i,
    input  logic [rv_pkg::xlen-1:0]      trap_vector_i,
    output logic [rv_pkg::xlen-1:0]      wb_data_o,
    output logic [rv_pkg::xlen-1:0]      next_pc_o,
    output logic                         branch_hazard_o
);

    logic [rv_pkg::xlen-1:0] pc_plus4;

    // Shared by the return address and the sequential next pc.
    assign pc_plus4 = pc_i + rv_pkg::xlen'(4);

    //////////////////////////////////////////////////
    // Write-back data select
    //////////////////////////////////////////////////

    always_comb begin
        case (wb_sel_i)
            rv_pkg::wb_memb: begin
                wb_data_o = {{(rv_pkg::xlen-8){mem_rdata_i[7]}}, mem_rdata_i[7:0]};
            end
            rv_pkg::wb_membu: begin
                wb_data_o = {{(rv_pkg::xlen-8){1'b0}}, mem_rdata_i[7:0]};
            end
            rv_pkg::wb_memh: begin
                wb_data_o = {{(rv_pkg::xlen-16){mem_rdata_i[15]}}, mem_rdata_i[15:0]};
            end
            rv_pkg::wb_memhu: begin
                wb_data_o = {{(rv_pkg::xlen-16){1'b0}}, mem_rdata_i[15:0]};
            end
            rv_pkg::wb_memw: begin
                wb_data_o = mem_rdata_i;
            end
            rv_pkg::wb_pc: begin
                wb_data_o = pc_plus4;
            end
            rv_pkg::wb_csr: begin
                wb_data_o = csr_rdata_i;
            end
            // wb_x and unknown codes.
            default: begin
                wb_data_o = alu_out_i;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // Redirect
    //////////////////////////////////////////////////

    next_pc_unit next_pc_unit_i (
        .pc_plus4_i      (pc_plus4),
        .br_flg_i        (br_flg_i),
        .br_target_i     (br_target_i),
        .jmp_flg_i       (jmp_flg_i),
        .alu_out_i       (alu_out_i),
        .csr_cmd_i       (csr_cmd_i),
        .trap_vector_i   (trap_vector_i),
        .next_pc_o       (next_pc_o),
        .branch_hazard_o (branch_hazard_o)
    );

endmodule

/* source/register_file.sv */
`timescale 1ns/10ps

module register_file #(
    parameter logic [rv_pkg::xlen-1:0] stack_top = 32'h0000_2000
) (
    input  logic                          clk,
    input  logic                          arst_n_i,
    input  logic                          we_i,
    input  logic [rv_pkg::reg_addr_w-1:0] waddr_i,
    input  logic [rv_pkg::xlen-1:0]       wdata_i,
    input  logic [rv_pkg::reg_addr_w-1:0] rs1_addr_i,
    input  logic [rv_pkg::reg_addr_w-1:0] rs2_addr_i,
    output logic [rv_pkg::xlen-1:0]       rs1_data_o,
    output logic [rv_pkg::xlen-1:0]       rs2_data_o
);

    localparam int num_regs = 2 ** rv_pkg::reg_addr_w;

    // x0 has no storage.
    logic [rv_pkg::xlen-1:0] regs [1:num_regs-1];

    logic wr_en;

    assign wr_en = (we_i == rv_pkg::ren_s) && (waddr_i != '0);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < num_regs; i++) begin
                regs[i] <= '1;
            end
            // Stack pointer starts at the top of data memory.
            regs[2] <= stack_top;
        end else if (wr_en) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    //////////////////////////////////////////////////
    // Read ports
    //////////////////////////////////////////////////

    always_comb begin
        if (rs1_addr_i == '0) begin
            rs1_data_o = '0;
        end else begin
            rs1_data_o = regs[rs1_addr_i];
        end
    end

    always_comb begin
        if (rs2_addr_i == '0) begin
            rs2_data_o = '0;
        end else begin
            rs2_data_o = regs[rs2_addr_i];
        end
    end

endmodule

/* source/retire_monitor.sv */
`timescale 1ns/10ps

module retire_monitor #(
    parameter logic [rv_pkg::xlen-1:0] exit_pc   = 32'hffff_ff00,
    parameter logic [rv_pkg::xlen-1:0] bubble_pc = 32'hffff_ffff
) (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  logic [rv_pkg::xlen-1:0] pc_i,
    output logic [31:0]             retire_count_o,
    output logic                    halt_o
);

    logic retire;

    // A bubble carries the reserved pc.
    assign retire = (pc_i != bubble_pc);

    //////////////////////////////////////////////////
    // Retired-instruction counter
    //////////////////////////////////////////////////

    // Keeps counting after halt.
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            retire_count_o <= '0;
        end else if (retire) begin
            retire_count_o <= retire_count_o + 32'd1;
        end
    end

    //////////////////////////////////////////////////
    // Halt flag
    //////////////////////////////////////////////////

    // Sticky until the next reset.
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            halt_o <= 1'b0;
        end else if (pc_i == exit_pc) begin
            halt_o <= 1'b1;
        end
    end

endmodule

/* source/wb_core_top.sv */
`timescale 1ns/10ps

module wb_core_top #(
    parameter logic [rv_pkg::xlen-1:0] stack_top = 32'h0000_2000,
    parameter logic [rv_pkg::xlen-1:0] exit_pc   = 32'hffff_ff00,
    parameter logic [rv_pkg::xlen-1:0] bubble_pc = 32'hffff_ffff
) (
    input  logic                          clk,
    input  logic                          arst_n_i,
    input  logic [rv_pkg::xlen-1:0]       pc_i,
    input  logic [rv_pkg::wb_sel_w-1:0]   wb_sel_i,
    input  logic [rv_pkg::xlen-1:0]       csr_rdata_i,
    input  logic [rv_pkg::xlen-1:0]       mem_rdata_i,
    input  logic [rv_pkg::xlen-1:0]       alu_out_i,
    input  logic                          br_flg_i,
    input  logic [rv_pkg::xlen-1:0]       br_target_i,
    input  logic                          jmp_flg_i,
    input  logic [rv_pkg::csr_cmd_w-1:0]  csr_cmd_i,
    input  logic [rv_pkg::xlen-1:0]       trap_vector_i,
    input  logic [rv_pkg::reg_addr_w-1:0] wb_addr_i,
    input  logic                          rf_wen_i,
    input  logic [rv_pkg::reg_addr_w-1:0] rs1_addr_i,
    input  logic [rv_pkg::reg_addr_w-1:0] rs2_addr_i,
    output logic [rv_pkg::xlen-1:0]       next_pc_o,
    output logic                          branch_hazard_o,
    output logic [rv_pkg::xlen-1:0]       rs1_data_o,
    output logic [rv_pkg::xlen-1:0]       rs2_data_o,
    output logic [31:0]                   retire_count_o,
    output logic                          halt_o
);

    logic [rv_pkg::xlen-1:0] wb_data;

    writeback_stage writeback_stage_i (
        .pc_i            (pc_i),
        .wb_sel_i        (wb_sel_i),
        .csr_rdata_i     (csr_rdata_i),
        .mem_rdata_i     (mem_rdata_i),
        .alu_out_i       (alu_out_i),
        .br_flg_i        (br_flg_i),
        .br_target_i     (br_target_i),
        .jmp_flg_i       (jmp_flg_i),
        .csr_cmd_i       (csr_cmd_i),
        .trap_vector_i   (trap_vector_i),
        .wb_data_o       (wb_data),
        .next_pc_o       (next_pc_o),
        .branch_hazard_o (branch_hazard_o)
    );

    register_file #(
        .stack_top (stack_top)
    ) register_file_i (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .we_i       (rf_wen_i),
        .waddr_i    (wb_addr_i),
        .wdata_i    (wb_data),
        .rs1_addr_i (rs1_addr_i),
        .rs2_addr_i (rs2_addr_i),
        .rs1_data_o (rs1_data_o),
        .rs2_data_o (rs2_data_o)
    );

    retire_monitor #(
        .exit_pc   (exit_pc),
        .bubble_pc (bubble_pc)
    ) retire_monitor_i (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .pc_i           (pc_i),
        .retire_count_o (retire_count_o),
        .halt_o         (halt_o)
    );

endmodule

/* tb/wb_vectors.svh */
// Columns: name, pc, wb_sel, csr_cmd, br_flg, jmp_flg, write, wb_addr,
// expected next-pc source, expected hazard.
`ifndef WB_VECTORS_SVH
`define WB_VECTORS_SVH

task automatic build_table();
    // Write-back select, one code per row.
    add_row("alu", 32'h0000_0100, rv_pkg::wb_x, rv_pkg::csr_x, 0, 0, 1, 5'd5, nxt_seq, 0);
    add_row("lb", 32'h0000_0104, rv_pkg::wb_memb, rv_pkg::csr_x, 0, 0, 1, 5'd6, nxt_seq, 0);
    add_row("lbu", 32'h0000_0108, rv_pkg::wb_membu, rv_pkg::csr_x, 0, 0, 1, 5'd7, nxt_seq, 0);
    add_row("lh", 32'h0000_010c, rv_pkg::wb_memh, rv_pkg::csr_x, 0, 0, 1, 5'd8, nxt_seq, 0);
    add_row("lhu", 32'h0000_0110, rv_pkg::wb_memhu, rv_pkg::csr_x, 0, 0, 1, 5'd9, nxt_seq, 0);
    add_row("lw", 32'h0000_0114, rv_pkg::wb_memw, rv_pkg::csr_x, 0, 0, 1, 5'd10, nxt_seq, 0);
    add_row("jal_ra", 32'h0000_0118, rv_pkg::wb_pc, rv_pkg::csr_x, 0, 1, 1, 5'd1, nxt_jmp, 1);
    add_row("csrrw", 32'h0000_011c, rv_pkg::wb_csr, rv_pkg::csr_w, 0, 0, 1, 5'd11, nxt_seq, 0);
    add_row("csrrs", 32'h0000_0120, rv_pkg::wb_csr, rv_pkg::csr_s, 0, 0, 1, 5'd12, nxt_seq, 0);
    add_row("csrrc", 32'h0000_0124, rv_pkg::wb_csr, rv_pkg::csr_c, 0, 0, 1, 5'd13, nxt_seq, 0);
    add_row("bubble", bubble_pc, rv_pkg::wb_x, rv_pkg::csr_x, 0, 0, 0, 5'd14, nxt_seq, 0);

    // Write rules.
    add_row("wr_x0", 32'h0000_0128, rv_pkg::wb_x, rv_pkg::csr_x, 0, 0, 1, 5'd0, nxt_seq, 0);
    add_row("wen_off", 32'h0000_012c, rv_pkg::wb_memw, rv_pkg::csr_x, 0, 0, 0, 5'd5, nxt_seq, 0);
    add_row("sel_unk", 32'h0000_0130, 4'd12, rv_pkg::csr_x, 0, 0, 1, 5'd15, nxt_seq, 0);

    // Redirect priority.
    add_row("ecall", 32'h0000_0134, rv_pkg::wb_x, rv_pkg::csr_ecall, 0, 0, 0, 5'd0, nxt_trap, 1);
    add_row("mret", 32'h0000_0138, rv_pkg::wb_x, rv_pkg::csr_mret, 0, 0, 0, 5'd0, nxt_trap, 1);
    add_row("sret", 32'h0000_013c, rv_pkg::wb_x, rv_pkg::csr_sret, 0, 0, 0, 5'd0, nxt_trap, 1);
    add_row("br_over_jmp", 32'h0000_0140, rv_pkg::wb_x, rv_pkg::csr_ecall, 1, 1, 0, 5'd0,
            nxt_br, 1);
    add_row("jmp_over_trap", 32'h0000_0144, rv_pkg::wb_pc, rv_pkg::csr_mret, 0, 1, 1, 5'd3,
            nxt_jmp, 1);
    add_row("br_only", 32'h0000_0148, rv_pkg::wb_x, rv_pkg::csr_x, 1, 0, 0, 5'd0, nxt_br, 1);

    // Retirement and halt.
    add_row("exit", exit_pc, rv_pkg::wb_x, rv_pkg::csr_x, 0, 0, 1, 5'd16, nxt_seq, 0);
    add_row("after_exit", 32'h0000_0200, rv_pkg::wb_x, rv_pkg::csr_x, 0, 0, 1, 5'd17, nxt_seq, 0);
    add_row("bubble2", bubble_pc, rv_pkg::wb_x, rv_pkg::csr_x, 0, 0, 0, 5'd0, nxt_seq, 0);
    add_row("after_exit2", 32'h0000_0204, rv_pkg::wb_memb, rv_pkg::csr_x, 0, 0, 1, 5'd18,
            nxt_seq, 0);
endtask

`endif

/* tb/tb_wb_core_top.sv */
`timescale 1ns/10ps

module tb_wb_core_top;

    localparam logic [31:0] stack_top = 32'h0000_2000;
    localparam logic [31:0] exit_pc   = 32'hffff_ff00;
    localparam logic [31:0] bubble_pc = 32'hffff_ffff;
    localparam logic [31:0] trap_vec  = 32'h0000_0800;
    localparam int max_rows = 40;

    // Expected next-pc source.
    localparam int nxt_seq  = 0;
    localparam int nxt_br   = 1;
    localparam int nxt_jmp  = 2;
    localparam int nxt_trap = 3;

    logic        clk;
    logic        arst_n_i;
    logic [31:0] pc_i;
    logic [3:0]  wb_sel_i;
    logic [31:0] csr_rdata_i;
    logic [31:0] mem_rdata_i;
    logic [31:0] alu_out_i;
    logic        br_flg_i;
    logic [31:0] br_target_i;
    logic        jmp_flg_i;
    logic [2:0]  csr_cmd_i;
    logic [31:0] trap_vector_i;
    logic [4:0]  wb_addr_i;
    logic        rf_wen_i;
    logic [4:0]  rs1_addr_i;
    logic [4:0]  rs2_addr_i;
    logic [31:0] next_pc_o;
    logic        branch_hazard_o;
    logic [31:0] rs1_data_o;
    logic [31:0] rs2_data_o;
    logic [31:0] retire_count_o;
    logic        halt_o;

    string       row_name [max_rows];
    logic [31:0] row_pc   [max_rows];
    logic [3:0]  row_sel  [max_rows];
    logic [2:0]  row_csr  [max_rows];
    logic        row_br   [max_rows];
    logic        row_jmp  [max_rows];
    logic        row_wen  [max_rows];
    logic [4:0]  row_addr [max_rows];
    int          row_src  [max_rows];
    logic        row_hz   [max_rows];
    int          num_rows = 0;

    logic [31:0] shadow [0:31];
    logic [31:0] lcg_state = 32'h43ae_221f;
    int          checks = 0;
    int          errors = 0;

    wb_core_top #(
        .stack_top (stack_top),
        .exit_pc   (exit_pc),
        .bubble_pc (bubble_pc)
    ) wb_core_top_i (.*);

    task automatic add_row(input string name, input logic [31:0] pc, input logic [3:0] sel,
                           input logic [2:0] csr, input logic br, input logic jmp,
                           input logic wen, input logic [4:0] addr, input int src,
                           input logic hz);
        row_name[num_rows] = name;
        row_pc[num_rows]   = pc;
        row_sel[num_rows]  = sel;
        row_csr[num_rows]  = csr;
        row_br[num_rows]   = br;
        row_jmp[num_rows]  = jmp;
        row_wen[num_rows]  = wen;
        row_addr[num_rows] = addr;
        row_src[num_rows]  = src;
        row_hz[num_rows]   = hz;
        num_rows++;
    endtask

    `include "wb_vectors.svh"

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] reset_value(input int idx);
        if (idx == 0) begin
            return 32'h0;
        end
        if (idx == 2) begin
            return stack_top;
        end
        return 32'hffff_ffff;
    endfunction

    // Reference model of the write-back select.
    function automatic logic [31:0] expected_wb_data(input logic [3:0] sel,
                                                     input logic [31:0] pc,
                                                     input logic [31:0] csr,
                                                     input logic [31:0] mem,
                                                     input logic [31:0] alu);
        case (sel)
            rv_pkg::wb_memb:  return {{24{mem[7]}}, mem[7:0]};
            rv_pkg::wb_membu: return {24'h0, mem[7:0]};
            rv_pkg::wb_memh:  return {{16{mem[15]}}, mem[15:0]};
            rv_pkg::wb_memhu: return {16'h0, mem[15:0]};
            rv_pkg::wb_memw:  return mem;
            rv_pkg::wb_pc:    return pc + 32'd4;
            rv_pkg::wb_csr:   return csr;
            default:          return alu;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Watchdog
    //////////////////////////////////////////////////

    initial begin
        int limit;
        #1;
        // Reset, reset readback, table rows, final readback and a margin.
        limit = 10 + 32 + num_rows + 1 + 20;
        #(limit * 10);
        $display("Watchdog timeout, the test did not finish in time");
        $display("STATUS: FAIL");
        $finish;
    end

    //////////////////////////////////////////////////
    // Stimulus and checks
    //////////////////////////////////////////////////

    initial begin
        int          k;
        int          prev_addr;
        int          exp_count;
        logic        exp_halt;
        logic [31:0] exp_npc;
        arst_n_i      = 1'b0;
        pc_i          = bubble_pc;
        wb_sel_i      = rv_pkg::wb_x;
        csr_rdata_i   = '0;
        mem_rdata_i   = '0;
        alu_out_i     = '0;
        br_flg_i      = 1'b0;
        br_target_i   = '0;
        jmp_flg_i     = 1'b0;
        csr_cmd_i     = rv_pkg::csr_x;
        trap_vector_i = trap_vec;
        wb_addr_i     = '0;
        rf_wen_i      = ~rv_pkg::ren_s;
        rs1_addr_i    = '0;
        rs2_addr_i    = '0;
        build_table();
        for (k = 0; k < 32; k++) begin
            shadow[k] = reset_value(k);
        end
        repeat (10) @(negedge clk);
        arst_n_i = 1'b1;

        // Reset values, read while bubbles retire.
        for (k = 0; k < 32; k++) begin
            @(negedge clk);
            rs1_addr_i = k[4:0];
            rs2_addr_i = 5'(31 - k);
            #1;
            check_value($sformatf("reset rs1 x%0d", k), reset_value(k), rs1_data_o);
            check_value($sformatf("reset rs2 x%0d", 31 - k), reset_value(31 - k), rs2_data_o);
        end
        check_value("reset halt", 32'(1'b0), 32'(halt_o));
        check_value("reset retire_count", 32'd0, retire_count_o);

        prev_addr = 0;
        exp_count = 0;
        exp_halt  = 1'b0;
        for (k = 0; k < num_rows; k++) begin
            @(negedge clk);
            pc_i          = row_pc[k];
            wb_sel_i      = row_sel[k];
            csr_cmd_i     = row_csr[k];
            br_flg_i      = row_br[k];
            jmp_flg_i     = row_jmp[k];
            rf_wen_i      = row_wen[k] ? rv_pkg::ren_s : ~rv_pkg::ren_s;
            wb_addr_i     = row_addr[k];
            // Byte and halfword sign bits set, so sign and zero extension differ.
            mem_rdata_i   = lcg_next() | 32'h0000_8080;
            alu_out_i     = lcg_next();
            csr_rdata_i   = lcg_next();
            br_target_i   = row_pc[k] + 32'h40;
            trap_vector_i = trap_vec;
            rs1_addr_i    = 5'(prev_addr);
            rs2_addr_i    = row_addr[k];
            #1;
            case (row_src[k])
                nxt_br:   exp_npc = br_target_i;
                nxt_jmp:  exp_npc = alu_out_i;
                nxt_trap: exp_npc = trap_vec;
                default:  exp_npc = row_pc[k] + 32'd4;
            endcase
            check_value({row_name[k], " next_pc"}, exp_npc, next_pc_o);
            check_value({row_name[k], " hazard"}, 32'(row_hz[k]), 32'(branch_hazard_o));
            check_value({row_name[k], " readback"}, shadow[prev_addr], rs1_data_o);
            check_value({row_name[k], " rs2"}, shadow[row_addr[k]], rs2_data_o);
            check_value({row_name[k], " retire_count"}, 32'(exp_count), retire_count_o);
            check_value({row_name[k], " halt"}, 32'(exp_halt), 32'(halt_o));
            if (row_wen[k] && row_addr[k] != 5'd0) begin
                shadow[row_addr[k]] = expected_wb_data(row_sel[k], row_pc[k], csr_rdata_i,
                                                       mem_rdata_i, alu_out_i);
            end
            if (row_pc[k] != bubble_pc) begin
                exp_count++;
            end
            if (row_pc[k] == exit_pc) begin
                exp_halt = 1'b1;
            end
            prev_addr = row_addr[k];
        end

        // Last row's write and the final counts.
        @(negedge clk);
        pc_i       = bubble_pc;
        rf_wen_i   = ~rv_pkg::ren_s;
        rs1_addr_i = 5'(prev_addr);
        #1;
        check_value("final readback", shadow[prev_addr], rs1_data_o);
        check_value("final retire_count", 32'(exp_count), retire_count_o);
        check_value("final halt", 32'(exp_halt), 32'(halt_o));

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+tb
common/rv_pkg.sv
writeback/next_pc_unit.sv
writeback/writeback_stage.sv
source/register_file.sv
source/retire_monitor.sv
source/wb_core_top.sv
tb/tb_wb_core_top.sv
